/* Makefile */
# Verilator build and run of the mempool_system testbench

VERILATOR ?= verilator
TOP       ?= tb_mempool_system
RTL_TOP   ?= mempool_system
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Verdict comes from the log, so a missing pass line fails the target
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
hdl/mempool_pkg.sv
hdl/system_map_pkg.sv
hdl/l2_bank.sv
hdl/l2_mem.sv
hdl/bootrom.sv
hdl/ctrl_registers.sv
hdl/system_addr_decode.sv
hdl/mempool_system.sv
test/tb_mempool_system.sv

/* hdl/bootrom.sv */
/*
  Boot ROM with a registered read port
*/

`timescale 1ns/1ns

module bootrom (
  input  logic               clk_i,
  input  logic               req_i,
  input  mempool_pkg::addr_t offset_i,
  output mempool_pkg::data_t rdata_o
);

  logic [$clog2(system_map_pkg::BootromNumWords)-1:0] word_idx;
  mempool_pkg::data_t                                 rdata_q;

  // Word index, byte lane bits dropped
  assign word_idx = offset_i[2 +: $clog2(system_map_pkg::BootromNumWords)];

  // Output only changes on a new read
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= system_map_pkg::BootromImage[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule : bootrom

/* hdl/ctrl_registers.sv */
/*
  Control block: core wake-up pulses, end-of-computation word, scratch words
*/

`timescale 1ns/1ns

module ctrl_registers (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  mempool_pkg::addr_t      offset_i,
  input  mempool_pkg::data_t      wdata_i,
  output mempool_pkg::data_t      rdata_o,
  output mempool_pkg::core_mask_t wake_up_o,
  output logic                    eoc_valid_o
);

  logic                                          wake_hit;
  logic                                          eoc_hit;
  logic                                          scratch_hit;
  mempool_pkg::addr_t                            scratch_off;
  logic [$clog2(system_map_pkg::NumScratch)-1:0] scratch_idx;
  mempool_pkg::data_t                            read_word;
  mempool_pkg::data_t                            rdata_q;
  mempool_pkg::data_t                            eoc_q;
  mempool_pkg::data_t                            scratch_q [system_map_pkg::NumScratch];
  mempool_pkg::core_mask_t                       wake_up_q;

  assign scratch_off = offset_i - system_map_pkg::ScratchOffset;
  assign scratch_idx = scratch_off[2 +: $clog2(system_map_pkg::NumScratch)];

  assign wake_hit    = (offset_i == system_map_pkg::WakeUpOffset);
  assign eoc_hit     = (offset_i == system_map_pkg::EocOffset);
  // Whole aligned words inside the scratch window
  assign scratch_hit = (scratch_off < 4 * system_map_pkg::NumScratch)
                       && (scratch_off[1:0] == 2'b00);

  // Wake-up register has no storage and reads as zero
  always_comb begin
    read_word = '0;
    if (eoc_hit) begin
      read_word = eoc_q;
    end else if (scratch_hit) begin
      read_word = scratch_q[scratch_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wake_up_q <= '0;
      eoc_q     <= '0;
      for (int i = 0; i < system_map_pkg::NumScratch; i++) begin
        scratch_q[i] <= '0;
      end
    end else begin
      // One-cycle pulse on the cores named in the write
      wake_up_q <= '0;
      if (req_i && we_i) begin
        if (wake_hit) begin
          wake_up_q <= wdata_i[mempool_pkg::NumCores-1:0];
        end
        if (eoc_hit) begin
          eoc_q <= wdata_i;
        end
        if (scratch_hit) begin
          scratch_q[scratch_idx] <= wdata_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= read_word;
    end
  end

  assign rdata_o     = rdata_q;
  assign wake_up_o   = wake_up_q;
  assign eoc_valid_o = eoc_q[0];

endmodule : ctrl_registers

/* hdl/l2_bank.sv */
/*
  Single-port SRAM bank with byte enables and registered read data
*/

`timescale 1ns/1ns

module l2_bank (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  mempool_pkg::bank_row_t row_i,
  input  mempool_pkg::data_t     wdata_i,
  input  mempool_pkg::strb_t     be_i,
  output mempool_pkg::data_t     rdata_o
);

  mempool_pkg::data_t mem [mempool_pkg::L2BankNumWords];
  mempool_pkg::data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < mempool_pkg::StrbWidth; b++) begin
          if (be_i[b]) begin
            mem[row_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[row_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule : l2_bank

/* hdl/l2_mem.sv */
/*
  L2 memory, words interleaved over the SRAM banks
*/

`timescale 1ns/1ns

module l2_mem (
  input  logic               clk_i,
  input  logic               req_i,
  input  logic               we_i,
  input  mempool_pkg::addr_t offset_i,
  input  mempool_pkg::data_t wdata_i,
  input  mempool_pkg::strb_t be_i,
  output mempool_pkg::data_t rdata_o
);

  mempool_pkg::bank_idx_t bank_sel;
  mempool_pkg::bank_idx_t bank_sel_q;
  mempool_pkg::bank_row_t bank_row;
  logic                   bank_req   [mempool_pkg::NumL2Banks];
  mempool_pkg::data_t     bank_rdata [mempool_pkg::NumL2Banks];

  // Byte offset in the low bits, then bank select, then row
  assign bank_sel = offset_i[2 +: $bits(mempool_pkg::bank_idx_t)];
  assign bank_row = offset_i[2 + $bits(mempool_pkg::bank_idx_t) +: $bits(mempool_pkg::bank_row_t)];

  for (genvar i = 0; i < mempool_pkg::NumL2Banks; i++) begin : gen_banks
    // Only the addressed bank sees the strobe
    assign bank_req[i] = req_i && (bank_sel == i);

    l2_bank i_l2_bank (
      .clk_i  (clk_i        ),
      .req_i  (bank_req[i]  ),
      .we_i   (we_i         ),
      .row_i  (bank_row     ),
      .wdata_i(wdata_i      ),
      .be_i   (be_i         ),
      .rdata_o(bank_rdata[i])
    );
  end

  // Bank of the request in flight, used to pick the response next cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      bank_sel_q <= bank_sel;
    end
  end

  assign rdata_o = bank_rdata[bank_sel_q];

endmodule : l2_mem

/* hdl/mempool_pkg.sv */
/*
  System widths, vector types and the core and L2 bank counts
*/

package mempool_pkg;

  // Host bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Byte address, data word and byte-enable mask
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // Cores that the control block can wake
  localparam int unsigned NumCores = 4;

  typedef logic [NumCores-1:0] core_mask_t;

  // L2 organisation, word interleaved over the banks
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 64;

  // Bank select and the row inside one bank
  typedef logic [$clog2(NumL2Banks)-1:0]     bank_idx_t;
  typedef logic [$clog2(L2BankNumWords)-1:0] bank_row_t;

endpackage : mempool_pkg

/* hdl/mempool_system.sv */
/*
  System top: host request port, address decoder, L2, boot ROM and control block
*/

`timescale 1ns/1ns

module mempool_system (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Host request
  input  logic                   req_i,
  input  logic                   we_i,
  input  mempool_pkg::addr_t     addr_i,
  input  mempool_pkg::data_t     wdata_i,
  input  mempool_pkg::strb_t     be_i,
  // Host response
  output logic                   rvalid_o,
  output mempool_pkg::data_t     rdata_o,
  output logic                   err_o,
  // Core control
  output mempool_pkg::core_mask_t wake_up_o,
  output logic                   eoc_valid_o
);

  logic               l2_req;
  logic               rom_req;
  logic               ctrl_req;
  mempool_pkg::addr_t offset;
  mempool_pkg::data_t l2_rdata;
  mempool_pkg::data_t rom_rdata;
  mempool_pkg::data_t ctrl_rdata;

  system_addr_decode i_system_addr_decode (
    .clk_i       (clk_i     ),
    .rst_i       (rst_i     ),
    .req_i       (req_i     ),
    .we_i        (we_i      ),
    .addr_i      (addr_i    ),
    .l2_rdata_i  (l2_rdata  ),
    .rom_rdata_i (rom_rdata ),
    .ctrl_rdata_i(ctrl_rdata),
    .l2_req_o    (l2_req    ),
    .rom_req_o   (rom_req   ),
    .ctrl_req_o  (ctrl_req  ),
    .offset_o    (offset    ),
    .rvalid_o    (rvalid_o  ),
    .rdata_o     (rdata_o   ),
    .err_o       (err_o     )
  );

  l2_mem i_l2_mem (
    .clk_i   (clk_i   ),
    .req_i   (l2_req  ),
    .we_i    (we_i    ),
    .offset_i(offset  ),
    .wdata_i (wdata_i ),
    .be_i    (be_i    ),
    .rdata_o (l2_rdata)
  );

  // Writes never reach the ROM, the decoder turns them into errors
  bootrom i_bootrom (
    .clk_i   (clk_i    ),
    .req_i   (rom_req  ),
    .offset_i(offset   ),
    .rdata_o (rom_rdata)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_i      (ctrl_req   ),
    .we_i       (we_i       ),
    .offset_i   (offset     ),
    .wdata_i    (wdata_i    ),
    .rdata_o    (ctrl_rdata ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

endmodule : mempool_system

/* hdl/system_addr_decode.sv */
/*
  Address decoder: region match, per-target strobes and response select
*/

`timescale 1ns/1ns

module system_addr_decode (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               req_i,
  input  logic               we_i,
  input  mempool_pkg::addr_t addr_i,
  input  mempool_pkg::data_t l2_rdata_i,
  input  mempool_pkg::data_t rom_rdata_i,
  input  mempool_pkg::data_t ctrl_rdata_i,
  output logic               l2_req_o,
  output logic               rom_req_o,
  output logic               ctrl_req_o,
  output mempool_pkg::addr_t offset_o,
  output logic               rvalid_o,
  output mempool_pkg::data_t rdata_o,
  output logic               err_o
);

  mempool_pkg::addr_t      l2_off;
  mempool_pkg::addr_t      rom_off;
  mempool_pkg::addr_t      ctrl_off;
  system_map_pkg::target_e tgt;
  system_map_pkg::target_e tgt_q;
  logic                    rvalid_q;
  logic                    err_q;

  // Offsets below the base wrap to large values and fail the size check
  assign l2_off   = addr_i - system_map_pkg::L2BaseAddr;
  assign rom_off  = addr_i - system_map_pkg::BootromBaseAddr;
  assign ctrl_off = addr_i - system_map_pkg::CtrlBaseAddr;

  always_comb begin
    tgt      = system_map_pkg::TgtNone;
    offset_o = '0;
    if (l2_off < system_map_pkg::L2Size) begin
      tgt      = system_map_pkg::TgtL2;
      offset_o = l2_off;
    end else if (rom_off < system_map_pkg::BootromSize && !we_i) begin
      tgt      = system_map_pkg::TgtBootrom;
      offset_o = rom_off;
    end else if (ctrl_off < system_map_pkg::CtrlSize) begin
      tgt      = system_map_pkg::TgtCtrl;
      offset_o = ctrl_off;
    end
  end

  assign l2_req_o   = req_i && (tgt == system_map_pkg::TgtL2);
  assign rom_req_o  = req_i && (tgt == system_map_pkg::TgtBootrom);
  assign ctrl_req_o = req_i && (tgt == system_map_pkg::TgtCtrl);

  // Every target answers one cycle after its strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      tgt_q    <= system_map_pkg::TgtNone;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i && (tgt == system_map_pkg::TgtNone);
      tgt_q    <= tgt;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (!err_q) begin
      case (tgt_q)
        system_map_pkg::TgtL2:      rdata_o = l2_rdata_i;
        system_map_pkg::TgtBootrom: rdata_o = rom_rdata_i;
        system_map_pkg::TgtCtrl:    rdata_o = ctrl_rdata_i;
        default:                    rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

endmodule : system_addr_decode

/* hdl/system_map_pkg.sv */
/*
  System address map, decoder targets, control register offsets and boot image
*/

package system_map_pkg;

  // Region bases and sizes in bytes
  localparam mempool_pkg::addr_t L2BaseAddr      = 32'h8000_0000;
  localparam mempool_pkg::addr_t L2Size          = 32'h0000_0400;
  localparam mempool_pkg::addr_t BootromBaseAddr = 32'hA000_0000;
  localparam mempool_pkg::addr_t BootromSize     = 32'h0000_0040;
  localparam mempool_pkg::addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam mempool_pkg::addr_t CtrlSize        = 32'h0000_1000;

  // Target picked by the address decoder
  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

  // Control register byte offsets
  localparam mempool_pkg::addr_t WakeUpOffset  = 32'h0000_0000;
  localparam mempool_pkg::addr_t EocOffset     = 32'h0000_0004;
  localparam mempool_pkg::addr_t ScratchOffset = 32'h0000_0010;

  localparam int unsigned NumScratch = 4;

  // Start-up code of the cores, ends in a jump to the L2 base
  localparam int unsigned BootromNumWords = 16;

  localparam mempool_pkg::data_t BootromImage [BootromNumWords] = '{
    32'hf140_2573, 32'h4000_05b7, 32'h0005_a023, 32'h1050_0073,
    32'h0045_a283, 32'hfe02_8ce3, 32'h8000_02b7, 32'h0002_8067,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_006f, 32'h0000_0000
  };

endpackage : system_map_pkg

/* test/tb_mempool_system.sv */
/*
  Testbench for mempool_system: clock, reset, directed tests with a host memory
  model, watchdog and final verdict
*/

`timescale 1ns/1ns

module tb_mempool_system;

  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned L2Words   = system_map_pkg::L2Size / 4;
  // Cycles per test in the order reset, reset state, L2, boot ROM, control, unmapped
  localparam int unsigned RunCycles = 6 + 3 + 25 + 19 + 19 + 8;
  localparam int unsigned Margin    = 50;

  logic                    clk_i;
  logic                    rst_i;
  logic                    req_i;
  logic                    we_i;
  mempool_pkg::addr_t      addr_i;
  mempool_pkg::data_t      wdata_i;
  mempool_pkg::strb_t      be_i;
  logic                    rvalid_o;
  mempool_pkg::data_t      rdata_o;
  logic                    err_o;
  mempool_pkg::core_mask_t wake_up_o;
  logic                    eoc_valid_o;

  // Host view of the memory map
  mempool_pkg::data_t l2_model      [L2Words];
  mempool_pkg::data_t scratch_model [system_map_pkg::NumScratch];
  mempool_pkg::data_t eoc_model;
  mempool_pkg::data_t lcg_state;
  int unsigned        error_count;

  // Expected response of the request sampled at the previous edge
  logic               pend_valid;
  logic               pend_err;
  logic               pend_read;
  mempool_pkg::data_t pend_data;

  mempool_system u_mempool_system (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_i      (req_i      ),
    .we_i       (we_i       ),
    .addr_i     (addr_i     ),
    .wdata_i    (wdata_i    ),
    .be_i       (be_i       ),
    .rvalid_o   (rvalid_o   ),
    .rdata_o    (rdata_o    ),
    .err_o      (err_o      ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic mempool_pkg::data_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic in_l2_region(input mempool_pkg::addr_t addr);
    return addr >= system_map_pkg::L2BaseAddr
           && addr < system_map_pkg::L2BaseAddr + system_map_pkg::L2Size;
  endfunction

  function automatic logic in_rom_region(input mempool_pkg::addr_t addr);
    return addr >= system_map_pkg::BootromBaseAddr
           && addr < system_map_pkg::BootromBaseAddr + system_map_pkg::BootromSize;
  endfunction

  function automatic logic in_ctrl_region(input mempool_pkg::addr_t addr);
    return addr >= system_map_pkg::CtrlBaseAddr
           && addr < system_map_pkg::CtrlBaseAddr + system_map_pkg::CtrlSize;
  endfunction

  function automatic logic is_scratch_offset(input mempool_pkg::addr_t off);
    return off >= system_map_pkg::ScratchOffset && off[1:0] == 2'b00
           && off < system_map_pkg::ScratchOffset + 4 * system_map_pkg::NumScratch;
  endfunction

  // Unmapped addresses and boot ROM writes answer with an error
  function automatic logic is_error_access(input logic we, input mempool_pkg::addr_t addr);
    return !(in_l2_region(addr) || (in_rom_region(addr) && !we) || in_ctrl_region(addr));
  endfunction

  function automatic mempool_pkg::data_t model_read(input mempool_pkg::addr_t addr);
    mempool_pkg::addr_t off;
    off = '0;
    if (in_l2_region(addr)) begin
      off = addr - system_map_pkg::L2BaseAddr;
      return l2_model[off >> 2];
    end else if (in_rom_region(addr)) begin
      off = addr - system_map_pkg::BootromBaseAddr;
      return system_map_pkg::BootromImage[off >> 2];
    end
    off = addr - system_map_pkg::CtrlBaseAddr;
    if (off == system_map_pkg::EocOffset) begin
      return eoc_model;
    end else if (is_scratch_offset(off)) begin
      return scratch_model[(off - system_map_pkg::ScratchOffset) >> 2];
    end
    return '0;
  endfunction

  task automatic model_write(input mempool_pkg::addr_t addr, input mempool_pkg::data_t wdata,
                             input mempool_pkg::strb_t be);
    mempool_pkg::addr_t off;
    if (in_l2_region(addr)) begin
      off = addr - system_map_pkg::L2BaseAddr;
      for (int b = 0; b < mempool_pkg::StrbWidth; b++) begin
        if (be[b]) l2_model[off >> 2][8*b +: 8] = wdata[8*b +: 8];
      end
    end else if (in_ctrl_region(addr)) begin
      off = addr - system_map_pkg::CtrlBaseAddr;
      if (off == system_map_pkg::EocOffset) begin
        eoc_model = wdata;
      end else if (is_scratch_offset(off)) begin
        scratch_model[(off - system_map_pkg::ScratchOffset) >> 2] = wdata;
      end
    end
  endtask

  task automatic report_mismatch(input string name, input mempool_pkg::data_t got,
                                 input mempool_pkg::data_t exp);
    error_count++;
    $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    $display("CHECKS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  // Mid-cycle check of the response to the previous request
  task automatic check_response();
    @(negedge clk_i);
    assert (rvalid_o === pend_valid)
      else report_mismatch("rvalid_o", 32'(rvalid_o), 32'(pend_valid));
    if (pend_valid) begin
      assert (err_o === pend_err) else report_mismatch("err_o", 32'(err_o), 32'(pend_err));
      if (pend_err || pend_read) begin
        assert (rdata_o === pend_data) else report_mismatch("rdata_o", rdata_o, pend_data);
      end
    end else begin
      assert (err_o === 1'b0) else report_mismatch("err_o", 32'(err_o), 32'd0);
    end
  endtask

  task automatic access(input logic we, input mempool_pkg::addr_t addr,
                        input mempool_pkg::data_t wdata, input mempool_pkg::strb_t be);
    logic               err;
    mempool_pkg::data_t exp;
    err = is_error_access(we, addr);
    exp = '0;
    if (!err && !we) exp = model_read(addr);
    if (!err && we) model_write(addr, wdata, be);
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
    check_response();
    pend_valid = 1'b1;
    pend_err   = err;
    pend_read  = !we;
    pend_data  = exp;
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    check_response();
    pend_valid = 1'b0;
  endtask

  task automatic check_ctrl_outputs(input mempool_pkg::core_mask_t wake, input logic eoc);
    assert (wake_up_o === wake) else report_mismatch("wake_up_o", 32'(wake_up_o), 32'(wake));
    assert (eoc_valid_o === eoc)
      else report_mismatch("eoc_valid_o", 32'(eoc_valid_o), 32'(eoc));
  endtask

  task automatic test_reset_state();
    idle_cycle();
    check_ctrl_outputs('0, 1'b0);
    access(1'b0, system_map_pkg::CtrlBaseAddr + system_map_pkg::ScratchOffset, '0, '0);
    idle_cycle();
  endtask

  task automatic test_l2_readback();
    mempool_pkg::addr_t addrs [8];
    mempool_pkg::data_t rnd;
    // Random rows with the bank cycling so that every bank is hit twice
    for (int i = 0; i < 8; i++) begin
      rnd = next_random();
      addrs[i] = system_map_pkg::L2BaseAddr
                 + ((rnd % mempool_pkg::L2BankNumWords) * mempool_pkg::NumL2Banks + i % 4) * 4;
      access(1'b1, addrs[i], next_random(), 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      rnd = next_random();
      access(1'b1, addrs[i], next_random(), rnd[7:4]);
    end
    for (int i = 0; i < 8; i++) begin
      access(1'b0, addrs[i], '0, '0);
    end
    idle_cycle();
  endtask

  task automatic test_bootrom();
    for (int w = 0; w < system_map_pkg::BootromNumWords; w++) begin
      access(1'b0, system_map_pkg::BootromBaseAddr + 4 * w, '0, '0);
    end
    access(1'b1, system_map_pkg::BootromBaseAddr + 8, next_random(), 4'hf);
    access(1'b0, system_map_pkg::BootromBaseAddr + 8, '0, '0);
    idle_cycle();
  endtask

  task automatic test_ctrl_registers();
    mempool_pkg::addr_t base;
    base = system_map_pkg::CtrlBaseAddr;
    // Pulse shows up only in the cycle after the write
    access(1'b1, base + system_map_pkg::WakeUpOffset, 32'h0000_000a, 4'hf);
    check_ctrl_outputs('0, 1'b0);
    idle_cycle();
    check_ctrl_outputs(4'ha, 1'b0);
    idle_cycle();
    check_ctrl_outputs('0, 1'b0);
    access(1'b0, base + system_map_pkg::WakeUpOffset, '0, '0);
    access(1'b1, base + system_map_pkg::EocOffset, 32'h0000_0003, 4'hf);
    idle_cycle();
    check_ctrl_outputs('0, 1'b1);
    access(1'b0, base + system_map_pkg::EocOffset, '0, '0);
    access(1'b1, base + system_map_pkg::EocOffset, 32'h0000_0002, 4'hf);
    idle_cycle();
    check_ctrl_outputs('0, 1'b0);
    for (int i = 0; i < system_map_pkg::NumScratch; i++) begin
      access(1'b1, base + system_map_pkg::ScratchOffset + 4 * i, next_random(), 4'hf);
    end
    for (int i = 0; i < system_map_pkg::NumScratch; i++) begin
      access(1'b0, base + system_map_pkg::ScratchOffset + 4 * i, '0, '0);
    end
    access(1'b0, base + 32'h8, '0, '0);
    idle_cycle();
  endtask

  task automatic test_unmapped();
    // A wrapped L2 offset of any of the writes below lands on the first L2 word
    access(1'b1, system_map_pkg::L2BaseAddr, next_random(), 4'hf);
    access(1'b0, 32'h0000_1000, '0, '0);
    access(1'b1, 32'h0000_1000, next_random(), 4'hf);
    access(1'b0, 32'hC000_0000, '0, '0);
    access(1'b1, 32'hC000_0000, next_random(), 4'hf);
    // First word past the end of L2 must not alias onto it
    access(1'b1, system_map_pkg::L2BaseAddr + system_map_pkg::L2Size, next_random(), 4'hf);
    access(1'b0, system_map_pkg::L2BaseAddr, '0, '0);
    idle_cycle();
  endtask

  initial begin
    #((RunCycles + Margin) * ClkPeriod);
    $display("Timeout: the tests did not finish within %0d cycles", RunCycles + Margin);
    $display("CHECKS FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    be_i        = '0;
    eoc_model   = '0;
    lcg_state   = 32'heeaf_4dc2;
    error_count = 0;
    pend_valid  = 1'b0;
    pend_err    = 1'b0;
    pend_read   = 1'b0;
    pend_data   = '0;
    for (int i = 0; i < system_map_pkg::NumScratch; i++) begin
      scratch_model[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    test_reset_state();
    test_l2_readback();
    test_bootrom();
    test_ctrl_registers();
    test_unmapped();
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_mempool_system
